/* rtl/csr_file.sv */
`default_nettype none
`include "soc_defines.svh"

module csr_file (
    input  logic              clk,
    input  logic              reset,
    input  logic [11:0]       csr_addr,
    input  logic              csr_set,      // csrrsi
    input  logic              csr_clear,    // csrrci
    input  logic [4:0]        csr_uimm,
    input  logic              trap_enter,
    input  logic [`XLEN-1:0]  trap_pc,
    input  logic              trap_return,  // mret
    output logic [`XLEN-1:0]  csr_rdata,
    output logic              mie_bit,
    output logic [`XLEN-1:0]  mepc
);

    logic mie;    // mstatus bit 3
    logic mpie;   // mstatus bit 7

    assign mie_bit = mie;

    // read mux, unknown csr reads zero
    always_comb begin
        case (csr_addr)
            rv_isa_pkg::csr_mstatus: csr_rdata = {56'd0, mpie, 3'd0, mie, 3'd0};
            rv_isa_pkg::csr_mepc:    csr_rdata = mepc;
            default:                 csr_rdata = '0;
        endcase
    end

    // mstatus bits, trap takes priority over mret and csr writes
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            mie  <= 1'b0;   // interrupts off out of reset
            mpie <= 1'b0;
        end else if (trap_enter) begin
            mpie <= mie;
            mie  <= 1'b0;
        end else if (trap_return) begin
            mie  <= mpie;
            mpie <= 1'b1;
        end else if (csr_addr == rv_isa_pkg::csr_mstatus) begin
            // uimm is 5 bits so only MIE is reachable
            if (csr_set && csr_uimm[3])
                mie <= 1'b1;
            else if (csr_clear && csr_uimm[3])
                mie <= 1'b0;
        end
    end

    // return address, written on trap only
    always_ff @(posedge clk) begin
        if (trap_enter)
            mepc <= trap_pc;
    end

endmodule

`default_nettype wire

/* rtl/inst_rom.sv */
`default_nettype none
`include "soc_defines.svh"

module inst_rom (
    input  logic [`XLEN-1:0]  pc,
    output logic [31:0]       instruction
);

    localparam int AW = $clog2(`ROM_WORDS);

    logic [AW-1:0] word_addr;
    logic          in_range;

    assign word_addr = pc[AW+1:2];
    assign in_range  = (pc < `XLEN'(`ROM_WORDS * 4));   // past the rom reads nop

    always_comb begin
        instruction = `NOP_INSN;
        if (in_range) begin
            case (word_addr)
                // interrupt routine at ISR_BASE
                'h00: instruction = {12'h7F0, 5'd0, 3'b011, 5'd5,           // ld x5,0x7F0(x0)
                                     rv_isa_pkg::op_load};
                'h01: instruction = {7'h3F, 5'd5, 5'd0, 3'b011, 5'h18,      // sd x5,0x7F8(x0)
                                     rv_isa_pkg::op_store};
                'h02: instruction = {12'h302, 5'd0, 3'b000, 5'd0,           // mret
                                     rv_isa_pkg::op_system};
                // main program at RAM_BASE
                'h40: instruction = {rv_isa_pkg::csr_mstatus, 5'd8, 3'b110, // csrrsi mstatus,8
                                     5'd0, rv_isa_pkg::op_system};
                'h41: instruction = {20'h80001, 5'd6,                       // lui x6,0x80001
                                     rv_isa_pkg::op_lui};
                'h42: instruction = {7'h3F, 5'd6, 5'd0, 3'b011, 5'h18,      // sd x6,0x7F8(x0)
                                     rv_isa_pkg::op_store};
                'h43: instruction = {12'h7FF, 5'd6, 3'b000, 5'd6,           // addi x6,x6,0x7FF
                                     rv_isa_pkg::op_addi};
                'h44: instruction = {7'h3F, 5'd6, 5'd0, 3'b011, 5'h18,      // sd x6,0x7F8(x0)
                                     rv_isa_pkg::op_store};
                'h45: instruction = {1'b1, 10'h3F8, 1'b1, 8'hFF, 5'd0,      // jal x0,-16
                                     rv_isa_pkg::op_jal};
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

/* rtl/riscv64.sv */
`default_nettype none
`include "soc_defines.svh"

module riscv64 (
    input  logic              clk,
    input  logic              reset,
    input  logic [31:0]       instruction,
    output logic [`XLEN-1:0]  pc,
    output logic              heartbeat,
    input  logic [3:0]        interrupt_vector,
    output logic              interrupt_ack,
    output logic [`XLEN-1:0]  bus_address,
    output logic [`XLEN-1:0]  bus_write_data,
    output logic              bus_write_enable,
    output logic              bus_read_enable,
    input  logic [`XLEN-1:0]  bus_read_data
);

    logic [31:0]              ir;
    logic [`XLEN-1:0]         regs [0:31];     // x0 never written
    rv_isa_pkg::exec_state_e  state, next_state;
    logic [`XLEN-1:0]         next_pc;
    logic [4:0]               ld_rd;           // load target, ir is gone by cycle 3

    rv_isa_pkg::opcode_e      opcode;
    logic [4:0]               rd, rs1, rs2;
    logic [2:0]               funct3;
    logic [`XLEN-1:0]         imm_u, imm_i, imm_s, imm_j;
    logic [`XLEN-1:0]         rs1_val, rs2_val;
    logic [`XLEN-1:0]         ir_pc;           // address ir was fetched from
    logic                     take_irq, exec_ok;
    logic                     is_csrrsi, is_csrrci, is_mret;
    logic                     wb_en;
    logic [4:0]               wb_rd;
    logic [`XLEN-1:0]         wb_data;

    logic [`XLEN-1:0]         csr_rdata, mepc;
    logic                     mie_bit;

    // field decode
    assign opcode = rv_isa_pkg::opcode_e'(ir[6:0]);
    assign rd     = ir[11:7];
    assign funct3 = ir[14:12];
    assign rs1    = ir[19:15];
    assign rs2    = ir[24:20];
    assign imm_u  = {{32{ir[31]}}, ir[31:12], 12'd0};
    assign imm_i  = {{52{ir[31]}}, ir[31:20]};
    assign imm_s  = {{52{ir[31]}}, ir[31:25], ir[11:7]};
    assign imm_j  = {{43{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};

    assign rs1_val = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rs2_val = (rs2 == 5'd0) ? '0 : regs[rs2];

    // in st_exec pc is always one word ahead of ir
    assign ir_pc = pc - `XLEN'd4;

    assign is_csrrsi = (opcode == rv_isa_pkg::op_system) && (funct3 == 3'b110);
    assign is_csrrci = (opcode == rv_isa_pkg::op_system) && (funct3 == 3'b111);
    assign is_mret   = (opcode == rv_isa_pkg::op_system) && (funct3 == 3'b000)
                       && (ir[31:20] == 12'h302);

    // interrupt wins over the instruction in ir
    assign take_irq = (state == rv_isa_pkg::st_exec) && (interrupt_vector == `IRQ_EXT)
                      && mie_bit;
    assign exec_ok  = (state == rv_isa_pkg::st_exec) && !take_irq;

    csr_file csr_i (
        .clk         (clk),
        .reset       (reset),
        .csr_addr    (ir[31:20]),
        .csr_set     (exec_ok && is_csrrsi),
        .csr_clear   (exec_ok && is_csrrci),
        .csr_uimm    (rs1),           // uimm sits in the rs1 field
        .trap_enter  (take_irq),
        .trap_pc     (ir_pc),         // re-run ir after mret
        .trap_return (exec_ok && is_mret),
        .csr_rdata   (csr_rdata),
        .mie_bit     (mie_bit),
        .mepc        (mepc)
    );

    // next pc and state
    always_comb begin
        next_pc    = pc + `XLEN'd4;
        next_state = rv_isa_pkg::st_exec;
        case (state)
            rv_isa_pkg::st_exec: begin
                if (take_irq) begin
                    next_pc    = `ISR_BASE;
                    next_state = rv_isa_pkg::st_bubble;
                end else if (opcode == rv_isa_pkg::op_jal) begin
                    next_pc    = ir_pc + imm_j;
                    next_state = rv_isa_pkg::st_bubble;
                end else if (is_mret) begin
                    next_pc    = mepc;
                    next_state = rv_isa_pkg::st_bubble;
                end else if (opcode == rv_isa_pkg::op_load) begin
                    next_pc    = pc;                          // load cycle 1, hold
                    next_state = rv_isa_pkg::st_bubble;
                end
            end
            rv_isa_pkg::st_bubble: begin
                if (bus_read_enable) begin                    // load cycle 2
                    next_pc    = pc;
                    next_state = rv_isa_pkg::st_load_wait;
                end
            end
            default: ;                                        // load cycle 3 falls through
        endcase
    end

    // register write back
    always_comb begin
        wb_en   = 1'b0;
        wb_rd   = rd;
        wb_data = '0;
        if (state == rv_isa_pkg::st_load_wait) begin
            wb_en   = 1'b1;
            wb_rd   = ld_rd;
            wb_data = bus_read_data;
        end else if (exec_ok) begin
            case (opcode)
                rv_isa_pkg::op_lui:  begin wb_en = 1'b1; wb_data = imm_u; end
                rv_isa_pkg::op_addi: begin wb_en = 1'b1; wb_data = rs1_val + imm_i; end
                rv_isa_pkg::op_jal:  begin wb_en = 1'b1; wb_data = pc; end  // link
                rv_isa_pkg::op_system: begin
                    wb_en   = is_csrrsi || is_csrrci;                     // old csr value
                    wb_data = csr_rdata;
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wb_en && wb_rd != 5'd0)
            regs[wb_rd] <= wb_data;
    end

    // fetch and control
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            ir               <= `NOP_INSN;
            pc               <= `RAM_BASE;
            state            <= rv_isa_pkg::st_exec;
            heartbeat        <= 1'b0;
            interrupt_ack    <= 1'b0;
            bus_write_enable <= 1'b0;
            bus_read_enable  <= 1'b0;
        end else begin
            ir               <= instruction;   // every edge, bubbles drop it
            pc               <= next_pc;
            state            <= next_state;
            heartbeat        <= ~heartbeat;
            interrupt_ack    <= take_irq;      // one pulse, MIE drops with it
            bus_write_enable <= exec_ok && (opcode == rv_isa_pkg::op_store);
            // held through the bubble so data is there in cycle 3
            bus_read_enable  <= (exec_ok && (opcode == rv_isa_pkg::op_load))
                                || (state == rv_isa_pkg::st_bubble && bus_read_enable);
        end
    end

    // bus payload
    always_ff @(posedge clk) begin
        if (exec_ok && opcode == rv_isa_pkg::op_load) begin
            bus_address <= rs1_val + imm_i;
            ld_rd       <= rd;
        end
        if (exec_ok && opcode == rv_isa_pkg::op_store) begin
            bus_address    <= rs1_val + imm_s;
            bus_write_data <= rs2_val;
        end
    end

endmodule

`default_nettype wire

/* rtl/riscv_soc.sv */
`default_nettype none
`include "soc_defines.svh"

module riscv_soc (
    input  logic              clk,
    input  logic              reset,
    input  logic [`XLEN-1:0]  key_value,
    input  logic [3:0]        interrupt_vector,
    output logic [`XLEN-1:0]  pc,
    output logic              heartbeat,
    output logic              interrupt_ack,
    output logic [`XLEN-1:0]  art_data,
    output logic              art_valid
);

    logic [31:0]       instruction;
    logic [`XLEN-1:0]  bus_address;
    logic [`XLEN-1:0]  bus_write_data;
    logic              bus_write_enable;
    logic              bus_read_enable;
    logic [`XLEN-1:0]  bus_read_data;

    riscv64 core_i (
        .clk              (clk),
        .reset            (reset),
        .instruction      (instruction),
        .pc               (pc),                 // also feeds the rom
        .heartbeat        (heartbeat),
        .interrupt_vector (interrupt_vector),
        .interrupt_ack    (interrupt_ack),
        .bus_address      (bus_address),
        .bus_write_data   (bus_write_data),
        .bus_write_enable (bus_write_enable),
        .bus_read_enable  (bus_read_enable),
        .bus_read_data    (bus_read_data)
    );

    inst_rom rom_i (
        .pc          (pc),
        .instruction (instruction)
    );

    soc_bus bus_i (
        .clk              (clk),
        .reset            (reset),
        .bus_address      (bus_address),
        .bus_write_data   (bus_write_data),
        .bus_write_enable (bus_write_enable),
        .bus_read_enable  (bus_read_enable),
        .bus_read_data    (bus_read_data),
        .key_value        (key_value),
        .art_data         (art_data),
        .art_valid        (art_valid)
    );

endmodule

`default_nettype wire

/* rtl/rv_isa_pkg.sv */
`default_nettype none

package rv_isa_pkg;

    // major opcodes, ir[6:0]
    typedef enum logic [6:0] {
        op_lui    = 7'b0110111,
        op_jal    = 7'b1101111,
        op_addi   = 7'b0010011,   // op-imm group, only addi decoded
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_system = 7'b1110011    // csrrsi, csrrci, mret
    } opcode_e;

    // machine csrs that exist
    typedef enum logic [11:0] {
        csr_mstatus = 12'h300,
        csr_mepc    = 12'h341
    } csr_addr_e;

    // execute stage states
    typedef enum logic [1:0] {
        st_exec,        // ir holds a live instruction
        st_bubble,      // ir is a wrong fetch, drop it
        st_load_wait    // bus data ready, write rd
    } exec_state_e;

endpackage

`default_nettype wire

/* rtl/soc_bus.sv */
`default_nettype none
`include "soc_defines.svh"

module soc_bus (
    input  logic              clk,
    input  logic              reset,
    input  logic [`XLEN-1:0]  bus_address,
    input  logic [`XLEN-1:0]  bus_write_data,
    input  logic              bus_write_enable,
    input  logic              bus_read_enable,
    output logic [`XLEN-1:0]  bus_read_data,
    input  logic [`XLEN-1:0]  key_value,
    output logic [`XLEN-1:0]  art_data,
    output logic              art_valid
);

    soc_bus_pkg::bus_dev_e dev;
    logic                  art_write;

    // full address compare, no aliasing
    always_comb begin
        case (bus_address)
            `KEY_BASE: dev = soc_bus_pkg::dev_key;
            `ART_BASE: dev = soc_bus_pkg::dev_art;
            default:   dev = soc_bus_pkg::dev_none;
        endcase
    end

    // key is the only readable device
    assign bus_read_data = (bus_read_enable && dev == soc_bus_pkg::dev_key) ? key_value : '0;

    assign art_write = bus_write_enable && (dev == soc_bus_pkg::dev_art);   // others dropped

    always_ff @(posedge clk or negedge reset) begin
        if (!reset)
            art_valid <= 1'b0;
        else
            art_valid <= art_write;   // one-cycle strobe per store
    end

    always_ff @(posedge clk) begin
        if (art_write)
            art_data <= bus_write_data;
    end

endmodule

`default_nettype wire

/* rtl/soc_bus_pkg.sv */
`default_nettype none

package soc_bus_pkg;

    // which device a bus address hits
    typedef enum logic [1:0] {
        dev_none,   // unmapped, reads give zero
        dev_key,
        dev_art
    } bus_dev_e;

endpackage

`default_nettype wire

/* rtl/soc_defines.svh */
`ifndef SOC_DEFINES_SVH
`define SOC_DEFINES_SVH

// data path width
`define XLEN 64

// program layout
`define RAM_BASE 64'h0000_0000_0000_0100   // reset pc, main loop
`define ISR_BASE 64'h0000_0000_0000_0000   // interrupt routine entry

// memory-mapped devices
`define KEY_BASE 64'h0000_0000_0000_07F0   // key register, read only
`define ART_BASE 64'h0000_0000_0000_07F8   // print port, write only

// rom depth in 32-bit words, 0x000..0x1FC
`define ROM_WORDS 128

// interrupt_vector code for the external interrupt
`define IRQ_EXT 4'd1

// addi x0,x0,0
`define NOP_INSN 32'h0000_0013

`endif

/* run_sim.sh */
#!/usr/bin/env bash
# compile and run the soc testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_riscv_soc \
    -f vlog.f \
    -o tb_riscv_soc_sim

sim_output=$(./obj_dir/tb_riscv_soc_sim)
echo "$sim_output"

if grep -qx "Testbench passed" <<< "$sim_output"; then
    echo "simulation result: pass"
    exit 0
else
    echo "simulation result: fail"
    exit 1
fi

/* sim/tb_riscv_soc.sv */
`default_nettype none
`include "soc_defines.svh"

module tb_riscv_soc;

    // the two main loop values from lui 0x80001 and the addi after it
    localparam logic [63:0] lui_val  = 64'hFFFF_FFFF_8000_1000;
    localparam logic [63:0] addi_val = 64'hFFFF_FFFF_8000_17FF;

    logic        clk;
    logic        reset;
    logic [63:0] key_value;
    logic [3:0]  interrupt_vector;
    logic [63:0] pc;
    logic        heartbeat;
    logic        interrupt_ack;
    logic [63:0] art_data;
    logic        art_valid;

    int          errors;
    int          art_count;       // strobes seen since time 0
    int          ack_count;
    int unsigned main_idx;        // main-loop writes since reset
    logic        key_pending;     // next strobe belongs to the isr
    logic [63:0] ack_key;         // key driven when the ack came
    logic [63:0] want;
    logic        prev_reset;
    logic        prev_heartbeat;
    logic        prev_ack;
    logic        hung;            // set when a wait runs out so later waits fall through
    logic [63:0] rand_state;

    riscv_soc dut_i (
        .clk              (clk),
        .reset            (reset),
        .key_value        (key_value),
        .interrupt_vector (interrupt_vector),
        .pc               (pc),
        .heartbeat        (heartbeat),
        .interrupt_ack    (interrupt_ack),
        .art_data         (art_data),
        .art_valid        (art_valid)
    );

    always #50 clk = ~clk;   // period 100

    function automatic logic [63:0] lcg_next(input logic [63:0] s);
        return s * 64'd6364136223846793005 + 64'd1442695040888963407;
    endfunction

    // isr store comes first after an ack and lui/addi values alternate otherwise
    function automatic logic [63:0] expected_art(input int unsigned idx, input logic pending,
                                                 input logic [63:0] key);
        if (pending)
            return key;
        return idx[0] ? addi_val : lui_val;
    endfunction

    // sampled at posedge where outputs still hold the previous cycle
    always @(posedge clk) begin
        if (!reset) begin
            if (!prev_reset) begin   // skip the edge where reset was just applied
                assert (pc == `RAM_BASE) else begin
                    $display("ERROR pc got %h expected %h", pc, `RAM_BASE);
                    errors++;
                end
                assert (!interrupt_ack) else begin
                    $display("ERROR interrupt_ack got %h expected %h", interrupt_ack, 1'b0);
                    errors++;
                end
                assert (!art_valid) else begin
                    $display("ERROR art_valid got %h expected %h", art_valid, 1'b0);
                    errors++;
                end
            end
            main_idx    = 0;        // program restarts at the lui
            key_pending = 1'b0;
        end else begin
            if (!prev_reset) begin
                assert (pc == `RAM_BASE) else begin   // first cycle out of reset
                    $display("ERROR pc got %h expected %h", pc, `RAM_BASE);
                    errors++;
                end
            end else begin
                assert (heartbeat != prev_heartbeat) else begin
                    $display("ERROR heartbeat got %h expected %h", heartbeat, !prev_heartbeat);
                    errors++;
                end
            end
            // a strobe in the ack cycle is still a main-loop store
            if (art_valid) begin
                want = expected_art(main_idx, key_pending, ack_key);
                assert (art_data == want) else begin
                    $display("ERROR art_data got %h expected %h", art_data, want);
                    errors++;
                end
                if (key_pending)
                    key_pending = 1'b0;
                else
                    main_idx++;
                art_count++;
            end
            if (interrupt_ack) begin
                assert (!prev_ack) else begin
                    $display("interrupt_ack stayed high for more than one cycle");
                    errors++;
                end
                ack_key     = key_value;
                key_pending = 1'b1;
                ack_count++;
            end
        end
        prev_reset     = reset;
        prev_heartbeat = heartbeat;
        prev_ack       = interrupt_ack;
    end

    task automatic wait_strobes(input int n);
        int target;
        int cycles;
        target = art_count + n;
        cycles = 0;
        while (!hung && art_count < target) begin
            @(negedge clk);
            cycles++;
            if (cycles > 20 * n + 20 && art_count < target) begin
                $display("timeout while waiting for art_valid strobes");
                errors++;
                hung = 1'b1;
            end
        end
    endtask

    task automatic wait_ack(input int target);
        int cycles;
        cycles = 0;
        while (!hung && ack_count < target) begin
            @(negedge clk);
            cycles++;
            if (cycles > 30 && ack_count < target) begin
                $display("timeout while waiting for interrupt_ack");
                errors++;
                hung = 1'b1;
            end
        end
    endtask

    task automatic service_irq(input logic [63:0] key);
        int acks_before;
        acks_before      = ack_count;
        key_value        = key;           // held until the isr has read it
        interrupt_vector = `IRQ_EXT;
        wait_ack(acks_before + 1);
        interrupt_vector = 4'd0;          // release after the ack
        wait_strobes(3);                  // key first and then the main loop again
        assert (ack_count == acks_before + 1) else begin
            $display("one request gave %0d interrupt_ack pulses", ack_count - acks_before);
            errors++;
        end
    endtask

    task automatic hold_wrong_vector(input logic [3:0] code);
        int acks_before;
        int arts_before;
        acks_before      = ack_count;
        arts_before      = art_count;
        interrupt_vector = code;
        repeat (40) @(negedge clk);
        interrupt_vector = 4'd0;
        assert (ack_count == acks_before) else begin
            $display("interrupt_ack raised for vector code %0d", code);
            errors++;
        end
        assert (art_count - arts_before >= 12) else begin   // two strobes per six-cycle loop
            $display("main loop stopped writing while vector code %0d was held", code);
            errors++;
        end
    endtask

    task automatic reset_during_service();
        int acks_before;
        rand_state       = lcg_next(rand_state);
        key_value        = rand_state;
        interrupt_vector = `IRQ_EXT;
        wait_ack(ack_count + 1);
        reset            = 1'b0;          // isr still in its first cycles
        interrupt_vector = 4'd0;
        repeat (8) @(negedge clk);
        reset            = 1'b1;
        acks_before      = ack_count;
        wait_strobes(6);                  // monitor expects lui value first
        assert (ack_count == acks_before) else begin
            $display("interrupt_ack raised after reset with no request");
            errors++;
        end
    endtask

    initial begin
        clk              = 1'b0;
        reset            = 1'b0;
        key_value        = '0;
        interrupt_vector = 4'd0;
        errors           = 0;
        art_count        = 0;
        ack_count        = 0;
        main_idx         = 0;
        key_pending      = 1'b0;
        ack_key          = '0;
        want             = '0;
        prev_reset       = 1'b1;
        prev_heartbeat   = 1'b0;
        prev_ack         = 1'b0;
        hung             = 1'b0;
        rand_state       = 64'd54;

        repeat (8) @(negedge clk);
        reset = 1'b1;

        // free-running main loop
        wait_strobes(6);
        assert (ack_count == 0) else begin
            $display("interrupt_ack raised with no request");
            errors++;
        end

        for (int i = 0; i < 20; i++) begin
            rand_state = lcg_next(rand_state);
            service_irq(rand_state);
        end

        hold_wrong_vector(4'd0);
        hold_wrong_vector(4'd2);
        hold_wrong_vector(4'd15);

        reset_during_service();

        $display("errors %0d, art strobes %0d, interrupts %0d", errors, art_count, ack_count);
        if (errors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+rtl
rtl/rv_isa_pkg.sv
rtl/soc_bus_pkg.sv
rtl/csr_file.sv
rtl/riscv64.sv
rtl/inst_rom.sv
rtl/soc_bus.sv
rtl/riscv_soc.sv
sim/tb_riscv_soc.sv
